// ==== rtl/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int REG_COUNT = 32;

    // primary opcode field, bits 31:26.
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    // function field of R-type words, bits 5:0.
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;

    // ALU_ADD must stay the zero encoding so that an all-zero control word is a NOP.
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI} alu_op_t;

endpackage

`default_nettype wire

// ==== rtl/mips_pipe_pkg.sv ====
`default_nettype none

package mips_pipe_pkg;

    typedef struct packed {
        mips_isa_pkg::alu_op_t  alu_op;
        logic                   use_imm;
        mips_isa_pkg::word_t    imm;
        mips_isa_pkg::reg_idx_t dest;
        logic                   we;
        logic                   load;
        logic                   store;
    } ctl_t;

    typedef struct packed {
        ctl_t                ctl;
        mips_isa_pkg::word_t op_a;
        mips_isa_pkg::word_t op_b;
    } id_ex_t;

    typedef struct packed {
        logic                   we;
        mips_isa_pkg::reg_idx_t dest;
        mips_isa_pkg::word_t    result;
        logic                   load;
        logic                   store;
        mips_isa_pkg::word_t    store_data;
    } ex_mm_t;

    typedef struct packed {
        logic                   we;
        mips_isa_pkg::reg_idx_t dest;
        mips_isa_pkg::word_t    value;
    } mm_wb_t;

    typedef enum logic [1:0] {CMD_HOLD, CMD_LOAD, CMD_BUBBLE} stage_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/fwd_bus_if.sv ====
`default_nettype none

interface fwd_bus_if;
    logic                   ex_we;
    mips_isa_pkg::reg_idx_t ex_dest;
    mips_isa_pkg::word_t    ex_value;
    logic                   ex_load;
    logic                   mm_we;
    mips_isa_pkg::reg_idx_t mm_dest;
    mips_isa_pkg::word_t    mm_value;
    logic                   wb_we;
    mips_isa_pkg::reg_idx_t wb_dest;
    mips_isa_pkg::word_t    wb_value;

    modport ex_src (output ex_we, ex_dest, ex_value, ex_load);
    modport mm_src (output mm_we, mm_dest, mm_value);
    modport wb_src (output wb_we, wb_dest, wb_value);
    modport sink (input ex_we, ex_dest, ex_value, ex_load, mm_we, mm_dest, mm_value,
                  wb_we, wb_dest, wb_value);
endinterface

`default_nettype wire

// ==== rtl/pipe_ctrl.sv ====
`default_nettype none

module pipe_ctrl #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_isa_pkg::reg_idx_t    rs_i,
    input  mips_isa_pkg::reg_idx_t    rt_i,
    input  logic                      ibus_stall_i,
    input  logic                      dbus_stall_i,
    fwd_bus_if.sink                   fwd,
    output mips_isa_pkg::word_t       pc_o,
    output mips_pipe_pkg::stage_cmd_t if_id_cmd_o,
    output mips_pipe_pkg::stage_cmd_t id_ex_cmd_o,
    output mips_pipe_pkg::stage_cmd_t ex_mm_cmd_o,
    output mips_pipe_pkg::stage_cmd_t mm_wb_cmd_o
);
    mips_isa_pkg::word_t pc_q;
    logic                pc_advance;
    logic                load_use;

    // a load in EX cannot forward yet, so its consumer in decode waits one cycle.
    assign load_use = fwd.ex_load && (fwd.ex_dest != '0)
                      && ((fwd.ex_dest == rs_i) || (fwd.ex_dest == rt_i));

    always_comb begin
        pc_advance  = 1'b1;
        if_id_cmd_o = mips_pipe_pkg::CMD_LOAD;
        id_ex_cmd_o = mips_pipe_pkg::CMD_LOAD;
        ex_mm_cmd_o = mips_pipe_pkg::CMD_LOAD;
        mm_wb_cmd_o = mips_pipe_pkg::CMD_LOAD;
        if (dbus_stall_i) begin
            pc_advance  = 1'b0;
            if_id_cmd_o = mips_pipe_pkg::CMD_HOLD;
            id_ex_cmd_o = mips_pipe_pkg::CMD_HOLD;
            ex_mm_cmd_o = mips_pipe_pkg::CMD_HOLD;
            mm_wb_cmd_o = mips_pipe_pkg::CMD_BUBBLE;
        end else if (load_use || ibus_stall_i) begin
            // the front end waits and a NOP enters execute.
            pc_advance  = 1'b0;
            if_id_cmd_o = mips_pipe_pkg::CMD_HOLD;
            id_ex_cmd_o = mips_pipe_pkg::CMD_BUBBLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (pc_advance) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

    pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
    parameter type payload_t = mips_isa_pkg::word_t
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_pipe_pkg::stage_cmd_t cmd_i,
    input  payload_t                  d_i,
    output payload_t                  q_o
);
    payload_t q;

    // an all-zero payload is a NOP in every stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            case (cmd_i)
                mips_pipe_pkg::CMD_LOAD:   q <= d_i;
                mips_pipe_pkg::CMD_BUBBLE: q <= '0;
                default:                   q <= q;
            endcase
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_isa_pkg::reg_idx_t rs_i,
    input  mips_isa_pkg::reg_idx_t rt_i,
    output mips_isa_pkg::word_t    rs_data_o,
    output mips_isa_pkg::word_t    rt_data_o,
    input  mips_pipe_pkg::mm_wb_t  wr_i
);
    mips_isa_pkg::word_t regs_q [mips_isa_pkg::REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_isa_pkg::REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.dest != '0)) begin
            regs_q[wr_i.dest] <= wr_i.value;
        end
    end

    // reads see the old value; the WB forwarding path covers a write in the same cycle.
    assign rs_data_o = regs_q[rs_i];
    assign rt_data_o = regs_q[rt_i];

    r0_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_i.we && wr_i.dest == '0)
        |=> ((rs_i != '0) || (rs_data_o == '0)) && ((rt_i != '0) || (rt_data_o == '0)));

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
`default_nettype none

module decode (
    input  mips_isa_pkg::word_t    inst_i,
    output mips_isa_pkg::reg_idx_t rs_o,
    output mips_isa_pkg::reg_idx_t rt_o,
    output mips_pipe_pkg::ctl_t    ctl_o
);
    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_isa_pkg::word_t imm_sext;
    mips_isa_pkg::word_t imm_zext;

    assign opcode   = inst_i[31:26];
    assign funct    = inst_i[5:0];
    assign rs_o     = inst_i[25:21];
    assign rt_o     = inst_i[20:16];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'h0000, inst_i[15:0]};

    always_comb begin
        // start from a register-writing I-type and adjust per opcode.
        ctl_o         = '0;
        ctl_o.use_imm = 1'b1;
        ctl_o.imm     = imm_zext;
        ctl_o.dest    = rt_o;
        ctl_o.we      = 1'b1;
        case (opcode)
            mips_isa_pkg::OPC_RTYPE: begin
                ctl_o.use_imm = 1'b0;
                ctl_o.dest    = inst_i[15:11];
                case (funct)
                    mips_isa_pkg::FN_ADDU: ctl_o.alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: ctl_o.alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  ctl_o.alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   ctl_o.alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  ctl_o.alu_op = mips_isa_pkg::ALU_XOR;
                    default:               ctl_o = '0;
                endcase
            end
            mips_isa_pkg::OPC_ADDIU: begin
                ctl_o.alu_op = mips_isa_pkg::ALU_ADD;
                ctl_o.imm    = imm_sext;
            end
            mips_isa_pkg::OPC_ANDI: ctl_o.alu_op = mips_isa_pkg::ALU_AND;
            mips_isa_pkg::OPC_ORI:  ctl_o.alu_op = mips_isa_pkg::ALU_OR;
            mips_isa_pkg::OPC_XORI: ctl_o.alu_op = mips_isa_pkg::ALU_XOR;
            mips_isa_pkg::OPC_LUI:  ctl_o.alu_op = mips_isa_pkg::ALU_LUI;
            mips_isa_pkg::OPC_LW: begin
                ctl_o.imm  = imm_sext;
                ctl_o.load = 1'b1;
            end
            mips_isa_pkg::OPC_SW: begin
                ctl_o.imm   = imm_sext;
                ctl_o.dest  = '0;
                ctl_o.we    = 1'b0;
                ctl_o.store = 1'b1;
            end
            default: ctl_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/operand_fwd.sv ====
`default_nettype none

module operand_fwd (
    input  mips_isa_pkg::reg_idx_t idx_i,
    input  mips_isa_pkg::word_t    reg_data_i,
    fwd_bus_if.sink                fwd,
    output mips_isa_pkg::word_t    data_o
);
    logic ex_hit;
    logic mm_hit;
    logic wb_hit;

    // register zero never forwards.
    assign ex_hit = fwd.ex_we && !fwd.ex_load && (fwd.ex_dest != '0) && (fwd.ex_dest == idx_i);
    assign mm_hit = fwd.mm_we && (fwd.mm_dest != '0) && (fwd.mm_dest == idx_i);
    assign wb_hit = fwd.wb_we && (fwd.wb_dest != '0) && (fwd.wb_dest == idx_i);

    always_comb begin
        if (ex_hit) begin
            data_o = fwd.ex_value;
        end else if (mm_hit) begin
            data_o = fwd.mm_value;
        end else if (wb_hit) begin
            data_o = fwd.wb_value;
        end else begin
            data_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
`default_nettype none

module execute (
    input  mips_pipe_pkg::id_ex_t ex_i,
    output mips_pipe_pkg::ex_mm_t ex_o,
    fwd_bus_if.ex_src             fwd
);
    mips_isa_pkg::word_t opnd_b;
    mips_isa_pkg::word_t result;

    assign opnd_b = ex_i.ctl.use_imm ? ex_i.ctl.imm : ex_i.op_b;

    // loads and stores use ALU_ADD, so the result doubles as the data address.
    always_comb begin
        case (ex_i.ctl.alu_op)
            mips_isa_pkg::ALU_SUB: result = ex_i.op_a - opnd_b;
            mips_isa_pkg::ALU_AND: result = ex_i.op_a & opnd_b;
            mips_isa_pkg::ALU_OR:  result = ex_i.op_a | opnd_b;
            mips_isa_pkg::ALU_XOR: result = ex_i.op_a ^ opnd_b;
            mips_isa_pkg::ALU_LUI: result = {opnd_b[15:0], 16'h0000};
            default:               result = ex_i.op_a + opnd_b;
        endcase
    end

    assign ex_o.we         = ex_i.ctl.we;
    assign ex_o.dest       = ex_i.ctl.dest;
    assign ex_o.result     = result;
    assign ex_o.load       = ex_i.ctl.load;
    assign ex_o.store      = ex_i.ctl.store;
    assign ex_o.store_data = ex_i.op_b;

    assign fwd.ex_we    = ex_i.ctl.we;
    assign fwd.ex_dest  = ex_i.ctl.dest;
    assign fwd.ex_value = result;
    assign fwd.ex_load  = ex_i.ctl.load;

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  mips_pipe_pkg::ex_mm_t ex_mm_i,
    output mips_isa_pkg::word_t   dbus_address_o,
    output logic                  dbus_read_o,
    output logic                  dbus_write_o,
    output mips_isa_pkg::word_t   dbus_wrdata_o,
    input  mips_isa_pkg::word_t   dbus_rddata_i,
    output mips_pipe_pkg::mm_wb_t mm_wb_o,
    fwd_bus_if.mm_src             fwd
);
    mips_isa_pkg::word_t value;

    // the EX/MM register holds during a data-bus stall, which keeps these outputs steady.
    assign dbus_address_o = ex_mm_i.result;
    assign dbus_read_o    = ex_mm_i.load;
    assign dbus_write_o   = ex_mm_i.store;
    assign dbus_wrdata_o  = ex_mm_i.store_data;

    assign value = ex_mm_i.load ? dbus_rddata_i : ex_mm_i.result;

    assign mm_wb_o.we    = ex_mm_i.we;
    assign mm_wb_o.dest  = ex_mm_i.dest;
    assign mm_wb_o.value = value;

    assign fwd.mm_we    = ex_mm_i.we;
    assign fwd.mm_dest  = ex_mm_i.dest;
    assign fwd.mm_value = value;

    always_comb begin
        rd_wr_excl_a: assert (!(dbus_read_o && dbus_write_o));
    end

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`default_nettype none

module mips_core #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n,
    output mips_isa_pkg::word_t ibus_address_o,
    input  mips_isa_pkg::word_t ibus_rddata_i,
    input  logic                ibus_stall_i,
    output mips_isa_pkg::word_t dbus_address_o,
    output logic                dbus_read_o,
    output logic                dbus_write_o,
    output mips_isa_pkg::word_t dbus_wrdata_o,
    input  mips_isa_pkg::word_t dbus_rddata_i,
    input  logic                dbus_stall_i
);
    mips_pipe_pkg::stage_cmd_t if_id_cmd;
    mips_pipe_pkg::stage_cmd_t id_ex_cmd;
    mips_pipe_pkg::stage_cmd_t ex_mm_cmd;
    mips_pipe_pkg::stage_cmd_t mm_wb_cmd;

    mips_isa_pkg::word_t       if_id_q;
    mips_isa_pkg::reg_idx_t    id_rs;
    mips_isa_pkg::reg_idx_t    id_rt;
    mips_isa_pkg::word_t       rs_data;
    mips_isa_pkg::word_t       rt_data;
    mips_pipe_pkg::ctl_t       id_ctl;
    mips_pipe_pkg::id_ex_t     id_ex_d;
    mips_pipe_pkg::id_ex_t     id_ex_q;
    mips_pipe_pkg::ex_mm_t     ex_mm_d;
    mips_pipe_pkg::ex_mm_t     ex_mm_q;
    mips_pipe_pkg::mm_wb_t     mm_wb_d;
    mips_pipe_pkg::mm_wb_t     mm_wb_q;

    fwd_bus_if fwd_bus ();

    pipe_ctrl #(.RESET_PC(RESET_PC)) pipe_ctrl_i (
        .clk(clk), .rst_n(rst_n), .rs_i(id_rs), .rt_i(id_rt),
        .ibus_stall_i(ibus_stall_i), .dbus_stall_i(dbus_stall_i), .fwd(fwd_bus.sink),
        .pc_o(ibus_address_o), .if_id_cmd_o(if_id_cmd), .id_ex_cmd_o(id_ex_cmd),
        .ex_mm_cmd_o(ex_mm_cmd), .mm_wb_cmd_o(mm_wb_cmd)
    );

    pipe_reg #(.payload_t(mips_isa_pkg::word_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .cmd_i(if_id_cmd), .d_i(ibus_rddata_i), .q_o(if_id_q)
    );

    decode decode_i (.inst_i(if_id_q), .rs_o(id_rs), .rt_o(id_rt), .ctl_o(id_ctl));

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n), .rs_i(id_rs), .rt_i(id_rt),
        .rs_data_o(rs_data), .rt_data_o(rt_data), .wr_i(mm_wb_q)
    );

    operand_fwd fwd_rs (.idx_i(id_rs), .reg_data_i(rs_data), .fwd(fwd_bus.sink),
                        .data_o(id_ex_d.op_a));
    operand_fwd fwd_rt (.idx_i(id_rt), .reg_data_i(rt_data), .fwd(fwd_bus.sink),
                        .data_o(id_ex_d.op_b));

    assign id_ex_d.ctl = id_ctl;

    pipe_reg #(.payload_t(mips_pipe_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .cmd_i(id_ex_cmd), .d_i(id_ex_d), .q_o(id_ex_q)
    );

    execute execute_i (.ex_i(id_ex_q), .ex_o(ex_mm_d), .fwd(fwd_bus.ex_src));

    pipe_reg #(.payload_t(mips_pipe_pkg::ex_mm_t)) ex_mm_reg (
        .clk(clk), .rst_n(rst_n), .cmd_i(ex_mm_cmd), .d_i(ex_mm_d), .q_o(ex_mm_q)
    );

    mem_stage mem_stage_i (
        .ex_mm_i(ex_mm_q), .dbus_address_o(dbus_address_o), .dbus_read_o(dbus_read_o),
        .dbus_write_o(dbus_write_o), .dbus_wrdata_o(dbus_wrdata_o),
        .dbus_rddata_i(dbus_rddata_i), .mm_wb_o(mm_wb_d), .fwd(fwd_bus.mm_src)
    );

    pipe_reg #(.payload_t(mips_pipe_pkg::mm_wb_t)) mm_wb_reg (
        .clk(clk), .rst_n(rst_n), .cmd_i(mm_wb_cmd), .d_i(mm_wb_d), .q_o(mm_wb_q)
    );

    // write-back source for the forwarding bus.
    assign fwd_bus.wb_we    = mm_wb_q.we;
    assign fwd_bus.wb_dest  = mm_wb_q.dest;
    assign fwd_bus.wb_value = mm_wb_q.value;

endmodule

`default_nettype wire

// ==== test/mips_core_tb.sv ====
`default_nettype none

module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN     = 32;
    localparam int STORE_MAX    = 16;
    localparam int DMEM_WORDS   = 64;
    localparam int STORE_WAIT   = 400;
    localparam int DRAIN_CYCLES = 40;

    // SW $0, 0($0). If a stalled fetch were ever consumed it would show up as a stray store.
    localparam mips_isa_pkg::word_t IBUS_JUNK = 32'hac00_0000;

    typedef struct packed {
        mips_isa_pkg::word_t inst;
        logic                is_store;
        mips_isa_pkg::word_t addr;
        mips_isa_pkg::word_t data;
    } prog_entry_t;

    logic                clk;
    logic                rst_n;
    mips_isa_pkg::word_t ibus_address;
    mips_isa_pkg::word_t ibus_rddata;
    logic                ibus_stall;
    mips_isa_pkg::word_t dbus_address;
    logic                dbus_read;
    logic                dbus_write;
    mips_isa_pkg::word_t dbus_wrdata;
    mips_isa_pkg::word_t dbus_rddata;
    logic                dbus_stall;

    prog_entry_t         prog [PROG_LEN];
    int                  prog_fill;
    mips_isa_pkg::word_t fetch_idx;
    mips_isa_pkg::word_t dmem [DMEM_WORDS];
    mips_isa_pkg::word_t got_addr [STORE_MAX];
    mips_isa_pkg::word_t got_data [STORE_MAX];
    int                  store_count;
    logic                stall_en;
    mips_isa_pkg::word_t rng_state;
    int                  checks;
    int                  value_errors;
    int                  timeouts;

    mips_core #(.RESET_PC(32'h0000_0000)) mips_core_i (
        .clk(clk), .rst_n(rst_n),
        .ibus_address_o(ibus_address), .ibus_rddata_i(ibus_rddata), .ibus_stall_i(ibus_stall),
        .dbus_address_o(dbus_address), .dbus_read_o(dbus_read), .dbus_write_o(dbus_write),
        .dbus_wrdata_o(dbus_wrdata), .dbus_rddata_i(dbus_rddata), .dbus_stall_i(dbus_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mips_isa_pkg::word_t xorshift(input mips_isa_pkg::word_t x);
        mips_isa_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mips_isa_pkg::word_t rtype(input int unsigned rs, input int unsigned rt,
                                                  input int unsigned rd, input logic [5:0] fn);
        return {mips_isa_pkg::OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t itype(input logic [5:0] op, input int unsigned rs,
                                                  input int unsigned rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // instruction memory. Past the table it returns zero, which decodes as a NOP.
    assign fetch_idx = ibus_address >> 2;

    always_comb begin
        if (ibus_stall) begin
            ibus_rddata = IBUS_JUNK;
        end else if (fetch_idx < PROG_LEN) begin
            ibus_rddata = prog[fetch_idx[4:0]].inst;
        end else begin
            ibus_rddata = '0;
        end
    end

    assign dbus_rddata = dbus_read ? dmem[dbus_address[7:2]] : '0;

    // data memory and store recorder, sampled mid-cycle where the bus is stable.
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= 32'(i) * 32'h0101_0101;
            end
            store_count <= 0;
        end else if (dbus_write && !dbus_stall) begin
            dmem[dbus_address[7:2]] <= dbus_wrdata;
            if (store_count < STORE_MAX) begin
                got_addr[store_count] <= dbus_address;
                got_data[store_count] <= dbus_wrdata;
            end
            store_count <= store_count + 1;
        end
    end

    // bus stalls change 1 ns after the rising edge.
    initial begin
        ibus_stall = 1'b0;
        dbus_stall = 1'b0;
        rng_state  = 32'd57;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                rng_state  = xorshift(rng_state);
                ibus_stall = rng_state[2:0] < 3'd3;
                dbus_stall = rng_state[10:8] < 3'd2;
            end else begin
                ibus_stall = 1'b0;
                dbus_stall = 1'b0;
            end
        end
    end

    task automatic add_inst(input mips_isa_pkg::word_t inst);
        prog[prog_fill] = '{inst, 1'b0, 32'h0, 32'h0};
        prog_fill++;
    endtask

    task automatic add_store(input mips_isa_pkg::word_t inst, input mips_isa_pkg::word_t addr,
                             input mips_isa_pkg::word_t data);
        prog[prog_fill] = '{inst, 1'b1, addr, data};
        prog_fill++;
    endtask

    task automatic build_program();
        // dependent ALU chain. Each result feeds the next instruction at once.
        add_inst(itype(mips_isa_pkg::OPC_LUI, 0, 1, 16'h1234));
        add_inst(itype(mips_isa_pkg::OPC_ORI, 1, 1, 16'h5678));
        add_inst(itype(mips_isa_pkg::OPC_ADDIU, 0, 2, 16'hffff));
        add_inst(rtype(1, 2, 3, mips_isa_pkg::FN_ADDU));
        add_inst(rtype(3, 1, 4, mips_isa_pkg::FN_SUBU));
        add_inst(rtype(4, 1, 5, mips_isa_pkg::FN_AND));
        add_inst(rtype(5, 2, 6, mips_isa_pkg::FN_XOR));
        add_inst(itype(mips_isa_pkg::OPC_ANDI, 6, 7, 16'hf0f0));
        add_inst(itype(mips_isa_pkg::OPC_XORI, 7, 8, 16'hffff));
        add_inst(rtype(8, 6, 9, mips_isa_pkg::FN_OR));
        add_inst(itype(mips_isa_pkg::OPC_ADDIU, 0, 10, 16'h0040));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 3, 16'h0000), 32'h40, 32'h1234_5677);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 4, 16'h0004), 32'h44, 32'hffff_ffff);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 5, 16'h0008), 32'h48, 32'h1234_5678);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 6, 16'h000c), 32'h4c, 32'hedcb_a987);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 7, 16'h0010), 32'h50, 32'h0000_a080);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 8, 16'h0014), 32'h54, 32'h0000_5f7f);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 9, 16'h0018), 32'h58, 32'hedcb_ffff);
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 1, 16'hfffc), 32'h3c, 32'h1234_5678);
        // loads whose result is used by the very next instruction.
        add_inst(itype(mips_isa_pkg::OPC_LW, 0, 11, 16'h0008));
        add_inst(rtype(11, 1, 12, mips_isa_pkg::FN_ADDU));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 12, 16'h0020), 32'h60, 32'h1436_587a);
        add_inst(itype(mips_isa_pkg::OPC_LW, 10, 13, 16'h0000));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 13, 16'h0024), 32'h64, 32'h1234_5677);
        add_inst(itype(mips_isa_pkg::OPC_LW, 0, 14, 16'h000c));
        add_inst(rtype(14, 11, 15, mips_isa_pkg::FN_SUBU));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 15, 16'h0028), 32'h68, 32'h0101_0101);
        // register zero stays zero, and ADDI and SLT are not implemented.
        add_inst(itype(mips_isa_pkg::OPC_ADDIU, 0, 0, 16'h0055));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 0, 16'h002c), 32'h6c, 32'h0000_0000);
        add_inst(itype(6'h08, 3, 3, 16'h0001));
        add_inst(rtype(1, 2, 3, 6'h2a));
        add_store(itype(mips_isa_pkg::OPC_SW, 10, 3, 16'h0030), 32'h70, 32'h1234_5677);
    endtask

    task automatic check_word(input string name, input mips_isa_pkg::word_t got,
                              input mips_isa_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("** Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_word("ibus_address_o", ibus_address, 32'h0);
        check_bit("dbus_read_o", dbus_read, 1'b0);
        check_bit("dbus_write_o", dbus_write, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
    endtask

    task automatic run_program(input string label);
        int i;
        int k;
        int waited;
        k = 0;
        for (i = 0; i < PROG_LEN && timeouts == 0; i++) begin
            if (prog[i].is_store) begin
                waited = 0;
                while (store_count <= k && waited < STORE_WAIT) begin
                    @(posedge clk);
                    waited++;
                end
                if (store_count <= k) begin
                    timeouts++;
                    $display("timeout in the %s run: store %0d never reached the data bus",
                             label, k);
                end else begin
                    check_word("dbus_address_o", got_addr[k], prog[i].addr);
                    check_word("dbus_wrdata_o", got_data[k], prog[i].data);
                    k++;
                end
            end
        end
        if (timeouts == 0) begin
            // the rest of the program is NOPs, so the store count must stay put.
            repeat (DRAIN_CYCLES) @(posedge clk);
            checks++;
            assert (store_count == k) else begin
                value_errors++;
                $display("** Error at %0t: dbus_write_o count = %0d, expected %0d",
                         $time, store_count, k);
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        stall_en     = 1'b0;
        prog_fill    = 0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        build_program();
        apply_reset();
        run_program("stall-free");
        if (timeouts == 0) begin
            apply_reset();
            stall_en = 1'b1;
            run_program("random-stall");
            stall_en = 1'b0;
        end
        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/fwd_bus_if.sv
rtl/pipe_ctrl.sv
rtl/pipe_reg.sv
rtl/reg_file.sv
rtl/decode.sv
rtl/operand_fwd.sv
rtl/execute.sv
rtl/mem_stage.sv
rtl/mips_core.sv
test/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_core_tb -f all.f \
    -Mdir obj_dir -o mips_core_sim
./obj_dir/mips_core_sim | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without a failure report"
